/* evt_xing_top.f */
hw/evt_xing_pkg.sv
hw/axil_evt_ctrl.sv
hw/pulse_sync_fifo.sv
hw/evt_sink.sv
hw/evt_xing_top.sv
verif/tb_evt_xing.sv

/* Bender.yml */
package:
  name: evt_xing

sources:
  # package first, then the design bottom up
  - hw/evt_xing_pkg.sv
  - hw/axil_evt_ctrl.sv
  - hw/pulse_sync_fifo.sv
  - hw/evt_sink.sv
  - hw/evt_xing_top.sv

  # testbench
  - target: test
    files:
      - verif/tb_evt_xing.sv

/* verif/tb_evt_xing.sv */
module tb_evt_xing;
  timeunit 1ns;
  timeprecision 1ps;

  import evt_xing_pkg::*;

  localparam int unsigned pat_n = 64;

  logic        clk = 1'b0;
  logic        clk_dst = 1'b0;
  logic        rrst_n;
  logic        rrst_n_dst;
  axil_aw_t    aw;
  logic        awready;
  axil_w_t     w;
  logic        wready;
  axil_b_t     b;
  logic        bready;
  axil_ar_t    ar;
  logic        arready;
  axil_r_t     r;
  logic        rready;
  evt_out_t    evt;
  logic        evt_ready;

  integer           seed;
  logic             rdy_lvl [pat_n];
  int unsigned      rdy_len [pat_n];
  int unsigned      pat_idx;
  int unsigned      run_left;
  logic             stall;
  int unsigned      queued;
  int unsigned      cycles;
  int unsigned      delivered;
  logic [seq_w-1:0] exp_seq;
  logic             prev_stall;
  evt_out_t         prev_evt;
  evt_out_t         exp_evt;

  always #4 clk = ~clk;
  always #5.5 clk_dst = ~clk_dst;

  evt_xing_top i_dut (
    .clk        (clk),
    .rrst_n     (rrst_n),
    .clk_dst    (clk_dst),
    .rrst_n_dst (rrst_n_dst),
    .aw         (aw),
    .awready    (awready),
    .w          (w),
    .wready     (wready),
    .b          (b),
    .bready     (bready),
    .ar         (ar),
    .arready    (arready),
    .r          (r),
    .rready     (rready),
    .evt        (evt),
    .evt_ready  (evt_ready)
  );

  task automatic stop_on_error();
    $display(">>> FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
    if (got !== exp)
    begin
      $display("Error: time %0.1f ns, %s is %0h, expected %0h", $realtime, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_rdata(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Error: time %0.1f ns, %s is %0h, expected %0h", $realtime, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_evt(input string name, input evt_out_t got, input evt_out_t exp);
    if (got !== exp)
    begin
      $display("Error: time %0.1f ns, %s is valid=%0b seq=%0d, expected valid=%0b seq=%0d",
               $realtime, name, got.valid, got.seq, exp.valid, exp.seq);
      stop_on_error();
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return {$random(seed)} % n;
  endfunction

  // each cycle ends 1 ns past the edge, ready to drive
  task automatic idle_cycles(input int unsigned n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output axil_resp_e resp);
    aw = '{valid: 1'b1, addr: addr};
    w  = '{valid: 1'b1, data: data, strb: 4'hf};
    do @(posedge clk); while (!(awready && wready));
    #1;
    aw.valid = 1'b0;
    w.valid  = 1'b0;
    // late bready so the slave has to hold b
    idle_cycles(rand_below(3));
    bready = 1'b1;
    do @(posedge clk); while (!b.valid);
    resp = b.resp;
    #1;
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output axil_resp_e resp);
    ar = '{valid: 1'b1, addr: addr};
    do @(posedge clk); while (!arready);
    #1;
    ar.valid = 1'b0;
    idle_cycles(rand_below(3));
    rready = 1'b1;
    do @(posedge clk); while (!r.valid);
    data = r.data;
    resp = r.resp;
    #1;
    rready = 1'b0;
  endtask

  // wait for the sink to deliver everything, then confirm nothing extra comes
  task automatic wait_drained(input int unsigned total);
    logic [31:0] data;
    axil_resp_e  resp;
    while (delivered < total)
      @(posedge clk);
    idle_cycles(40);
    check_rdata("delivered event count", delivered, total);
    axil_read(reg_pending, data, resp);
    check_resp("pending read resp", resp, resp_okay);
    check_rdata("pending after drain", data, 32'd0);
    axil_read(reg_issued, data, resp);
    check_resp("issued read resp", resp, resp_okay);
    check_rdata("issued after drain", data, total & 32'h0000_ffff);
  endtask

  // timeout scales with the events queued so far
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > 40 * queued + 2000)
    begin
      $display("Timeout after %0d cycles, events did not drain (%0d delivered)",
               cycles, delivered);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  // evt_ready duty pattern, forced low while stalled
  always @(posedge clk_dst)
  begin
    #1;
    if (rrst_n_dst || stall)
    begin
      evt_ready = 1'b0;
      run_left  = 0;
    end
    else if (run_left == 0)
    begin
      evt_ready = rdy_lvl[pat_idx];
      run_left  = rdy_len[pat_idx] - 1;
      pat_idx   = (pat_idx + 1) % pat_n;
    end
    else
    begin
      run_left = run_left - 1;
    end
  end

  // destination monitor, values seen before this edge updates them
  always @(posedge clk_dst)
  begin
    if (rrst_n_dst)
    begin
      prev_stall = 1'b0;
    end
    else
    begin
      if (prev_stall)
        check_evt("evt while stalled", evt, prev_evt);
      if (evt.valid && evt_ready)
      begin
        exp_evt.valid = 1'b1;
        exp_evt.seq   = exp_seq;
        check_evt("evt", evt, exp_evt);
        exp_seq   = exp_seq + 1'b1;
        delivered = delivered + 1;
      end
      prev_stall = evt.valid && !evt_ready;
      prev_evt   = evt;
    end
  end

  initial
  begin
    int unsigned amt;
    int unsigned trig_n;
    int unsigned total;
    int unsigned k;
    logic [3:0]  addr;
    logic [31:0] data;
    logic [31:0] pend_stall;
    axil_resp_e  resp;

    seed       = 77;
    aw         = '0;
    w          = '0;
    ar         = '0;
    bready     = 1'b0;
    rready     = 1'b0;
    evt_ready  = 1'b0;
    rrst_n     = 1'b1;
    rrst_n_dst = 1'b1;
    stall      = 1'b0;
    pat_idx    = 0;
    run_left   = 0;
    queued     = 0;
    cycles     = 0;
    delivered  = 0;
    exp_seq    = '0;
    prev_stall = 1'b0;
    prev_evt   = '0;
    exp_evt    = '0;
    trig_n     = 0;
    total      = 0;

    // alternating low and high runs, low ones longer
    for (int i = 0; i < pat_n; i++)
    begin
      rdy_lvl[i] = i[0];
      rdy_len[i] = i[0] ? 1 + rand_below(16) : 1 + rand_below(40);
    end

    fork
      begin
        repeat (8) @(posedge clk);
        #1 rrst_n = 1'b0;
      end
      begin
        repeat (8) @(posedge clk_dst);
        #1 rrst_n_dst = 1'b0;
      end
    join
    idle_cycles(2);

    // random mix of triggers, register reads and unmapped accesses
    for (int op = 0; op < 40; op++)
    begin
      case (rand_below(4))
        0, 1:
        begin
          if (trig_n < 20)
          begin
            amt    = 1 + rand_below(12);
            total  = total + amt;
            queued = queued + amt;
            trig_n = trig_n + 1;
            data   = ({$random(seed)} & 32'hffff_ff00) | amt;
            axil_write(reg_trigger, data, resp);
            check_resp("trigger write resp", resp, resp_okay);
          end
        end
        2:
        begin
          case (rand_below(6))
            0: addr = 4'h4;
            1: addr = 4'h8;
            2: addr = 4'h0;
            3: addr = 4'hc;
            4: addr = 4'h2;
            default: addr = 4'hf;
          endcase
          axil_read(addr, data, resp);
          if (addr == 4'h4 || addr == 4'h8)
          begin
            check_resp("mapped read resp", resp, resp_okay);
          end
          else
          begin
            check_resp("unmapped read resp", resp, resp_slverr);
            check_rdata("unmapped read data", data, 32'd0);
          end
        end
        default:
        begin
          addr = 4'h4 + 4'(rand_below(3) * 4);
          axil_write(addr, 32'h0000_00ff, resp);
          check_resp("unmapped write resp", resp, resp_slverr);
        end
      endcase
      idle_cycles(rand_below(6));
    end
    wait_drained(total);

    // saturation, with the consumer stalled so the crossing fills
    stall = 1'b1;
    idle_cycles(4);
    queued = queued + 200;
    axil_write(reg_trigger, 32'd200, resp);
    check_resp("trigger write resp", resp, resp_okay);
    axil_read(reg_pending, data, resp);
    // long enough for the read pointer to make its round trip
    do
    begin
      pend_stall = data;
      idle_cycles(20);
      axil_read(reg_pending, data, resp);
    end
    while (data != pend_stall);
    axil_read(reg_issued, data, resp);
    k = (data[15:0] - total[15:0]) & 16'hffff;
    // four in the crossing at most, one more in the sink register
    if (k == 0 || k > 5)
    begin
      $display("Error: time %0.1f ns, %0d events issued into a stalled sink, expected 1 to 5",
               $realtime, k);
      stop_on_error();
    end
    check_rdata("pending with crossing full", pend_stall, 200 - k);
    queued = queued + 200;
    axil_write(reg_trigger, 32'd200, resp);
    check_resp("trigger write resp", resp, resp_okay);
    axil_read(reg_pending, data, resp);
    check_rdata("saturated pending", data, 32'd255);
    total = total + k + 255;
    stall = 1'b0;
    wait_drained(total);

    $display(">>> PASS");
    $finish;
  end

endmodule

/* hw/evt_xing_top.sv */
module evt_xing_top (
  input  logic                   clk,
  input  logic                   rrst_n,
  input  logic                   clk_dst,
  input  logic                   rrst_n_dst,
  input  evt_xing_pkg::axil_aw_t aw,
  output logic                   awready,
  input  evt_xing_pkg::axil_w_t  w,
  output logic                   wready,
  output evt_xing_pkg::axil_b_t  b,
  input  logic                   bready,
  input  evt_xing_pkg::axil_ar_t ar,
  output logic                   arready,
  output evt_xing_pkg::axil_r_t  r,
  input  logic                   rready,
  output evt_xing_pkg::evt_out_t evt,
  input  logic                   evt_ready
);

  logic full;
  logic issue;
  logic avail;
  logic take;

  // source domain
  axil_evt_ctrl i_ctrl (
    .clk     (clk),
    .rrst_n  (rrst_n),
    .aw      (aw),
    .awready (awready),
    .w       (w),
    .wready  (wready),
    .b       (b),
    .bready  (bready),
    .ar      (ar),
    .arready (arready),
    .r       (r),
    .rready  (rready),
    .full    (full),
    .issue   (issue)
  );

  pulse_sync_fifo i_fifo (
    .clk       (clk),
    .rrst_n    (rrst_n),
    .clk_rd    (clk_dst),
    .rrst_rd_n (rrst_n_dst),
    .issue     (issue),
    .full      (full),
    .take      (take),
    .avail     (avail)
  );

  // destination domain
  evt_sink i_sink (
    .clk       (clk_dst),
    .rrst_n    (rrst_n_dst),
    .avail     (avail),
    .take      (take),
    .evt       (evt),
    .evt_ready (evt_ready)
  );

endmodule

/* hw/evt_sink.sv */
module evt_sink (
  input  logic                   clk,
  input  logic                   rrst_n,
  input  logic                   avail,
  output logic                   take,
  output evt_xing_pkg::evt_out_t evt,
  input  logic                   evt_ready
);

  import evt_xing_pkg::*;

  logic             evt_valid;
  logic [seq_w-1:0] evt_seq;
  logic [seq_w-1:0] seq_cnt;
  logic             load;

  // refill when empty or when the current event leaves this edge
  assign load = avail & (~evt_valid | evt_ready);
  assign take = load;

  assign evt = '{valid: evt_valid, seq: evt_seq};

  always_ff @(posedge clk)
  begin
    if (rrst_n)
    begin
      evt_valid <= 1'b0;
      seq_cnt   <= '0;
    end
    else if (load)
    begin
      evt_valid <= 1'b1;
      seq_cnt   <= seq_cnt + 1'b1;
    end
    else if (evt_ready)
    begin
      evt_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      evt_seq <= seq_cnt;
    end
  end

  // consumer stall must freeze the presented event
  a_evt_hold: assert property (@(posedge clk) disable iff (rrst_n)
    evt.valid && !evt_ready |=> $stable(evt));

endmodule

/* hw/pulse_sync_fifo.sv */
module pulse_sync_fifo (
  input  logic clk,
  input  logic rrst_n,
  input  logic clk_rd,
  input  logic rrst_rd_n,
  input  logic issue,
  output logic full,
  input  logic take,
  output logic avail
);

  import evt_xing_pkg::*;

  logic [ptr_w-1:0] wbin;
  logic [ptr_w-1:0] wptr;
  logic [ptr_w-1:0] wbin_next;
  logic [ptr_w-1:0] wbin_next2;
  logic [ptr_w-1:0] rptr_meta;
  logic [ptr_w-1:0] rptr_sync;

  logic [ptr_w-1:0] rbin;
  logic [ptr_w-1:0] rptr;
  logic [ptr_w-1:0] rbin_next;
  logic [ptr_w-1:0] wptr_meta;
  logic [ptr_w-1:0] wptr_sync;
  logic             rd_adv;

  // write side
  assign wbin_next  = wbin + ptr_w'(issue);
  assign wbin_next2 = wbin_next + 1'b1;

  // full looks one write past the current one
  // four apart in gray flips the top two bits
  assign full = (((wbin_next2 >> 1) ^ wbin_next2) ==
                 {~rptr_sync[ptr_w-1:ptr_w-2], rptr_sync[ptr_w-3:0]});

  always_ff @(posedge clk)
  begin
    if (rrst_n)
    begin
      wbin <= '0;
      wptr <= '0;
    end
    else
    begin
      wbin <= wbin_next;
      wptr <= (wbin_next >> 1) ^ wbin_next;
    end
  end

  // read pointer into the write domain
  always_ff @(posedge clk)
  begin
    if (rrst_n)
    begin
      rptr_meta <= '0;
      rptr_sync <= '0;
    end
    else
    begin
      rptr_meta <= rptr;
      rptr_sync <= rptr_meta;
    end
  end

  // read side
  assign avail     = (rptr != wptr_sync);
  assign rd_adv    = avail & take;
  assign rbin_next = rbin + ptr_w'(rd_adv);

  always_ff @(posedge clk_rd)
  begin
    if (rrst_rd_n)
    begin
      rbin <= '0;
      rptr <= '0;
    end
    else
    begin
      rbin <= rbin_next;
      rptr <= (rbin_next >> 1) ^ rbin_next;
    end
  end

  // write pointer into the read domain
  always_ff @(posedge clk_rd)
  begin
    if (rrst_rd_n)
    begin
      wptr_meta <= '0;
      wptr_sync <= '0;
    end
    else
    begin
      wptr_meta <= wptr;
      wptr_sync <= wptr_meta;
    end
  end

  // only one bit may move, or the far side can sample a torn value
  a_wgray_step: assert property (@(posedge clk) disable iff (rrst_n)
    $countones(wptr ^ $past(wptr)) <= 1);

endmodule

/* hw/axil_evt_ctrl.sv */
module axil_evt_ctrl (
  input  logic                   clk,
  input  logic                   rrst_n,
  input  evt_xing_pkg::axil_aw_t aw,
  output logic                   awready,
  input  evt_xing_pkg::axil_w_t  w,
  output logic                   wready,
  output evt_xing_pkg::axil_b_t  b,
  input  logic                   bready,
  input  evt_xing_pkg::axil_ar_t ar,
  output logic                   arready,
  output evt_xing_pkg::axil_r_t  r,
  input  logic                   rready,
  input  logic                   full,
  output logic                   issue
);

  import evt_xing_pkg::*;

  logic                wr_acc;
  logic                rd_acc;
  logic                b_valid;
  axil_resp_e          b_resp;
  logic                r_valid;
  logic [31:0]         r_data;
  axil_resp_e          r_resp;
  logic [pend_w-1:0]   pending;
  logic [pend_w-1:0]   trig_add;
  logic [pend_w:0]     pend_sum;
  logic [pend_w-1:0]   pend_sat;
  logic [issued_w-1:0] issued;
  logic                issue_d;

  // address and data only taken together, one response in flight
  assign wr_acc  = aw.valid & w.valid & ~b_valid;
  assign awready = wr_acc;
  assign wready  = wr_acc;

  assign rd_acc  = ar.valid & ~r_valid;
  assign arready = rd_acc;

  assign b = '{valid: b_valid, resp: b_resp};
  assign r = '{valid: r_valid, data: r_data, resp: r_resp};

  // trigger amount, zero unless a trigger write lands this cycle
  assign trig_add = (wr_acc && aw.addr == reg_trigger) ? w.data[pend_w-1:0] : '0;

  assign pend_sum = {1'b0, pending} + {1'b0, trig_add};
  assign pend_sat = pend_sum[pend_w] ? {pend_w{1'b1}} : pend_sum[pend_w-1:0];

  // full already counts the issue in flight this cycle
  assign issue_d = (pending != '0) & ~full;

  always_ff @(posedge clk)
  begin
    if (rrst_n)
    begin
      pending <= '0;
      issued  <= '0;
      issue   <= 1'b0;
    end
    else
    begin
      pending <= pend_sat - pend_w'(issue_d);
      issued  <= issued + issued_w'(issue);
      issue   <= issue_d;
    end
  end

  // write response channel
  always_ff @(posedge clk)
  begin
    if (rrst_n)
    begin
      b_valid <= 1'b0;
    end
    else if (wr_acc)
    begin
      b_valid <= 1'b1;
    end
    else if (bready)
    begin
      b_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_acc)
    begin
      b_resp <= (aw.addr == reg_trigger) ? resp_okay : resp_slverr;
    end
  end

  // read response channel
  always_ff @(posedge clk)
  begin
    if (rrst_n)
    begin
      r_valid <= 1'b0;
    end
    else if (rd_acc)
    begin
      r_valid <= 1'b1;
    end
    else if (rready)
    begin
      r_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_acc)
    begin
      case (ar.addr)
        reg_pending:
        begin
          r_data <= 32'(pending);
          r_resp <= resp_okay;
        end
        reg_issued:
        begin
          r_data <= 32'(issued);
          r_resp <= resp_okay;
        end
        default:
        begin
          r_data <= '0;
          r_resp <= resp_slverr;
        end
      endcase
    end
  end

  // response held until the manager takes it
  a_b_hold: assert property (@(posedge clk) disable iff (rrst_n)
    b.valid && !bready |=> b.valid && $stable(b));

  // buffer full in one cycle blocks the issue of the next
  a_no_issue_full: assert property (@(posedge clk) disable iff (rrst_n)
    full |=> !issue);

endmodule

/* hw/evt_xing_pkg.sv */
package evt_xing_pkg;

  // crossing pointer, one wrap bit above the slot index
  localparam int unsigned ptr_w    = 3;
  localparam int unsigned seq_w    = 8;
  localparam int unsigned pend_w   = 8;
  localparam int unsigned issued_w = 16;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axil_resp_e;

  // register map, byte addresses
  typedef enum logic [3:0] {
    reg_trigger = 4'h0,
    reg_pending = 4'h4,
    reg_issued  = 4'h8
  } axil_addr_e;

  typedef struct packed {
    logic       valid;
    logic [3:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic [3:0]  strb;
  } axil_w_t;

  typedef struct packed {
    logic       valid;
    axil_resp_e resp;
  } axil_b_t;

  typedef struct packed {
    logic       valid;
    logic [3:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    axil_resp_e  resp;
  } axil_r_t;

  typedef struct packed {
    logic             valid;
    logic [seq_w-1:0] seq;
  } evt_out_t;

endpackage
